// ==== list.f ====
hdl/lau_pkg.sv
hdl/sad_pkg.sv
hdl/prefix_and.sv
hdl/abs_val.sv
hdl/sad_lane.sv
hdl/sad_accumulator.sv
hdl/sad_unit.sv
dv/sad_unit_sva.sv
dv/sad_unit_tb.sv

// ==== dv/sad_unit_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for sad_unit with speed FAST.
// Inputs change on the falling edge. Outputs are checked on it too.
// Random rows use $random with seed 16. Expected totals come from a
// model of |cur - ref| summed per block, modulo 2**SUM_W.
// The run is bounded by a cycle limit sized from the table length.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sad_unit_tb import lau_pkg::*, sad_pkg::*; ();

	typedef struct packed {
		logic             valid;
		logic             first;
		logic             last;
		sad_item_t        item;
		logic [SUM_W-1:0] exp_sad;  // Meaningful on valid last rows
	} row_t;

	logic             clk;
	logic             rst;
	logic             in_valid;
	logic             in_first;
	logic             in_last;
	sad_item_t        in_item;
	logic             out_valid;
	logic [SUM_W-1:0] out_sad;

	row_t             rows[$];   // Stimulus table
	logic [SUM_W-1:0] exp_q[$];  // Totals still owed by the DUT
	integer           seed;
	int               checks = 0;
	int               errors = 0;
	int               cycles = 0;
	int               limit = 1000000;  // Replaced once the table exists

	sad_unit #(
		.speed (FAST)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_last   (in_last),
		.in_item   (in_item),
		.out_valid (out_valid),
		.out_sad   (out_sad)
	);

	bind sad_unit sad_unit_sva u_sva (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_last   (in_last),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// Lane g takes byte g of each word
	function automatic sad_item_t lanes_item(input logic [LANES*PIX_W-1:0] curs,
			input logic [LANES*PIX_W-1:0] refs);
		sad_item_t it;
		for (int g = 0; g < LANES; g++) begin
			it.pair[g].cur     = curs[g*PIX_W +: PIX_W];
			it.pair[g].ref_pix = refs[g*PIX_W +: PIX_W];
		end
		return it;
	endfunction

	function automatic sad_item_t random_item();
		sad_item_t it;
		it = {$random(seed), $random(seed)};
		return it;
	endfunction

	function automatic void add_row(input logic valid, input logic first,
			input logic last, input sad_item_t item);
		row_t r;
		r.valid   = valid;
		r.first   = first;
		r.last    = last;
		r.item    = item;
		r.exp_sad = '0;
		rows.push_back(r);
	endfunction

	// Plain integer distance per lane
	function automatic int item_sad(input sad_item_t it);
		int sum;
		int c;
		int r;
		sum = 0;
		for (int g = 0; g < LANES; g++) begin
			c = it.pair[g].cur;
			r = it.pair[g].ref_pix;
			sum += (c > r) ? c - r : r - c;
		end
		return sum;
	endfunction

	// Walks the table like the block framing rules
	function automatic void fill_expected_totals();
		int   total;
		row_t r;
		total = 0;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (r.valid) begin
				if (r.first) total = item_sad(r.item);  // New block
				else total = total + item_sad(r.item);
				total = total % (1 << SUM_W);  // Wraps like the hardware
				if (r.last) begin
					r.exp_sad = total[SUM_W-1:0];
					rows[i] = r;
				end
			end
		end
	endfunction

	task automatic build_table();
		int len;
		add_row(1'b0, 1'b0, 1'b0, '0);  // Quiet start
		add_row(1'b0, 1'b0, 1'b0, '0);
		// Single items, both signs, equal and off by one
		add_row(1'b1, 1'b1, 1'b1, lanes_item({8'd100, 8'd77, 8'd255, 8'd0},
			{8'd101, 8'd77, 8'd0, 8'd255}));
		add_row(1'b1, 1'b1, 1'b1, lanes_item({8'd0, 8'd1, 8'd255, 8'd101},
			{8'd0, 8'd0, 8'd255, 8'd100}));
		add_row(1'b1, 1'b1, 1'b1, lanes_item({4{8'd0}}, {4{8'd255}}));
		add_row(1'b1, 1'b1, 1'b1, lanes_item({4{8'd255}}, {4{8'd0}}));
		// Two blocks back to back with last then first
		add_row(1'b1, 1'b1, 1'b0, random_item());
		add_row(1'b1, 1'b0, 1'b1, random_item());
		add_row(1'b1, 1'b1, 1'b0, random_item());
		add_row(1'b1, 1'b0, 1'b0, random_item());
		add_row(1'b1, 1'b0, 1'b1, random_item());
		// Idle rows in a block carry junk and stray strobes
		add_row(1'b1, 1'b1, 1'b0, random_item());
		add_row(1'b0, 1'b1, 1'b1, random_item());
		add_row(1'b1, 1'b0, 1'b0, random_item());
		add_row(1'b0, 1'b0, 1'b0, random_item());
		add_row(1'b1, 1'b0, 1'b1, random_item());
		// Past MAX_BLOCK at full distance so the total wraps
		for (int k = 0; k < MAX_BLOCK + 4; k++) begin
			add_row(1'b1, k == 0, k == MAX_BLOCK + 3, lanes_item({4{8'd0}}, {4{8'd255}}));
		end
		// Random blocks with no gaps
		for (int b = 0; b < 12; b++) begin
			len = 1 + ($unsigned($random(seed)) % MAX_BLOCK);
			for (int k = 0; k < len; k++) begin
				add_row(1'b1, k == 0, k == len - 1, random_item());
			end
		end
	endtask

	// Outputs settle after the rising edge
	always @(negedge clk) begin : check_out
		logic [SUM_W-1:0] exp_sad;
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("out_valid pulsed at %0t with no block total expected", $time);
				errors++;
			end else begin
				exp_sad = exp_q.pop_front();
				checks++;
				if (out_sad !== exp_sad) begin
					$display("FAIL out_sad expected 0x%h got 0x%h", exp_sad, out_sad);
					errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles with %0d totals outstanding", cycles,
				exp_q.size());
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		rst      = 1'b1;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_last  = 1'b0;
		in_item  = '0;
		seed     = 16;
		build_table();
		fill_expected_totals();
		limit = 2 ** (log2floor(rows.size() + 20) + 1);  // Next power of two up
		repeat (5) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			in_valid = rows[i].valid;
			in_first = rows[i].first;
			in_last  = rows[i].last;
			in_item  = rows[i].item;
			if (rows[i].valid && rows[i].last) exp_q.push_back(rows[i].exp_sad);
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_first = 1'b0;
		in_last  = 1'b0;
		repeat (5) @(negedge clk);  // Two-cycle latency plus room for a stray pulse
		if (exp_q.size() != 0) begin
			$display("%0d block totals never came out", exp_q.size());
			errors++;
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/sad_unit_sva.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe timing checks for sad_unit, attached with bind.
// Expects reset only at the start of a run. in_last counts with in_valid.
// Latency from the sampled last item to out_valid is fixed at 2 cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sad_unit_sva (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_last,
	input logic out_valid
);

	// Sync clear, so low from the edge after the first reset edge
	a_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high while reset is held");

	// Every closed block produces its pulse
	a_last_to_out: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_last |-> ##2 out_valid)
		else $error("out_valid missing 2 cycles after a last item");

	// No pulse without a last item two edges back
	a_out_has_cause: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(in_valid && in_last, 2))
		else $error("out_valid without a sampled last item");

endmodule

`default_nettype wire

// ==== hdl/sad_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SAD unit top. Four lanes feed one block accumulator.
// No handshake and no stall. An item is taken every cycle in_valid is high.
// in_first and in_last count only with in_valid. A one-item block sets both.
// out_valid follows the sampled last item by exactly 2 cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sad_unit import lau_pkg::*, sad_pkg::*; #(
	parameter speed_e speed = FAST  // Prefix structure of the lanes
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  logic             in_first,
	input  logic             in_last,
	input  sad_item_t        in_item,
	output logic             out_valid,
	output logic [SUM_W-1:0] out_sad
);

	mag_vec_t mags;       // Lane stage outputs
	logic     mag_valid;  // Strobes delayed to match the lanes
	logic     mag_first;
	logic     mag_last;

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		sad_lane #(
			.speed (speed)
		) u_lane (
			.clk  (clk),
			.rst  (rst),
			.pair (in_item.pair[g]),
			.mag  (mags[g])
		);
	end

	// Same stage as the lane registers
	always_ff @(posedge clk) begin
		if (rst) begin
			mag_valid <= 1'b0;
			mag_first <= 1'b0;
			mag_last  <= 1'b0;
		end else begin
			mag_valid <= in_valid;
			mag_first <= in_first;
			mag_last  <= in_last;
		end
	end

	sad_accumulator u_acc (
		.clk       (clk),
		.rst       (rst),
		.mag_valid (mag_valid),
		.mag_first (mag_first),
		.mag_last  (mag_last),
		.mags      (mags),
		.out_valid (out_valid),
		.out_sad   (out_sad)
	);

endmodule

`default_nettype wire

// ==== hdl/sad_accumulator.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sums the lane magnitudes and accumulates them over a block.
// A valid first item restarts the total. Items with valid low are ignored.
// A valid last item pulses out_valid one cycle later with the block total.
// out_sad holds until the next pulse. Totals wrap modulo 2**SUM_W.
// The adder tree assumes LANES = 4.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sad_accumulator import sad_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             mag_valid,  // Item present
	input  logic             mag_first,  // Starts a block
	input  logic             mag_last,   // Ends a block
	input  mag_vec_t         mags,
	output logic             out_valid,  // One-cycle pulse per block
	output logic [SUM_W-1:0] out_sad     // Block total
);

	logic [LANES/2-1:0][PIX_W:0] pair_sum;    // Tree level one
	logic [PIX_W+1:0]            item_sum;    // Tree level two
	logic [SUM_W-1:0]            total;       // Running block total
	logic [SUM_W-1:0]            next_total;

	// Neighbouring lanes pairwise
	for (genvar g = 0; g < LANES/2; g++) begin : g_pair
		assign pair_sum[g] = {1'b0, mags[2*g]} + {1'b0, mags[2*g+1]};
	end

	assign item_sum = {1'b0, pair_sum[0]} + {1'b0, pair_sum[1]};

	// First item loads, later items add
	assign next_total = mag_first ? SUM_W'(item_sum) : total + SUM_W'(item_sum);

	always_ff @(posedge clk) begin
		if (rst) begin
			total     <= '0;
			out_valid <= 1'b0;
			out_sad   <= '0;
		end else begin
			out_valid <= mag_valid & mag_last;
			if (mag_valid) begin
				total <= next_total;
				if (mag_last) begin
					out_sad <= next_total;  // Includes the last item
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sad_lane.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One SAD lane. Registers |cur - ref| one cycle after the pair arrives.
// The difference is DIFF_W bits signed, so its magnitude fits PIX_W bits.
// No valid input, the register loads every cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sad_lane import lau_pkg::*, sad_pkg::*; #(
	parameter speed_e speed = FAST  // Prefix structure inside abs_val
) (
	input  logic             clk,
	input  logic             rst,
	input  pix_pair_t        pair,  // Current and reference pixel
	output logic [PIX_W-1:0] mag    // Registered magnitude
);

	logic [DIFF_W-1:0] diff;      // cur - ref, two's complement
	logic [DIFF_W-1:0] abs_diff;  // Top bit always zero here

	// Zero-extend both so the borrow lands in the sign bit
	assign diff = {1'b0, pair.cur} - {1'b0, pair.ref_pix};

	abs_val #(
		.width (DIFF_W),
		.speed (speed)
	) u_abs (
		.a (diff),
		.z (abs_diff)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			mag <= '0;
		end else begin
			mag <= abs_diff[PIX_W-1:0];  // At most 255
		end
	end

endmodule

`default_nettype wire

// ==== hdl/abs_val.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Absolute value of a two's-complement word.
// Negation is invert plus one, the increment done by a prefix AND.
// The most negative input comes back unchanged.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module abs_val import lau_pkg::*; #(
	parameter int     width = 8,    // Word width
	parameter speed_e speed = FAST  // Prefix structure
) (
	input  logic [width-1:0] a,  // Signed operand
	output logic [width-1:0] z   // Magnitude
);

	logic           neg;  // Sign doubles as negation enable
	logic [width:0] inv;  // Conditionally inverted a, carry-in at bit 0
	logic [width:0] pre;  // Running AND of carry-in and low bits

	assign neg = a[width-1];
	assign inv = {a ^ {width{neg}}, neg};

	prefix_and #(
		.width (width + 1),
		.speed (speed)
	) u_prefix (
		.pi (inv),
		.po (pre)
	);

	// Bit flips where all bits below it and the carry-in are one
	assign z = inv[width:1] ^ pre[width-1:0];

endmodule

`default_nettype wire

// ==== hdl/prefix_and.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Prefix AND. po[i] is the AND of pi[0] through pi[i].
// FAST is Sklansky with depth clog2(width) and high fan-out.
// MEDIUM is Brent-Kung with depth 2*clog2(width)-1 and fewer cells.
// SLOW is a serial chain of width-1 gates.
// All three give the same function. Purely combinational.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module prefix_and import lau_pkg::*; #(
	parameter int     width = 8,    // Word width
	parameter speed_e speed = FAST  // Prefix structure
) (
	input  logic [width-1:0] pi,  // Propagate in
	output logic [width-1:0] po   // Prefix AND out
);

	localparam int m = $clog2(width);  // Levels of the log tree

	if (speed == FAST) begin : g_sklansky
		wire [width-1:0] t [0:m];  // Row l is the word after level l

		assign t[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : g_level
			localparam int half = 2**(l-1);  // Half group size
			for (genvar i = 0; i < width; i++) begin : g_bit
				// Upper half of each group takes the lower half's top bit
				if ((i / half) % 2 == 1) begin : g_black
					assign t[l][i] = t[l-1][i]
						& t[l-1][(i / (2*half)) * (2*half) + half - 1];
				end else begin : g_white
					assign t[l][i] = t[l-1][i];  // Pass through
				end
			end
		end
		assign po = t[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		localparam int last = (m == 0) ? 0 : 2*m - 1;  // Final row

		wire [width-1:0] t [0:last];

		assign t[0] = pi;

		// Up-sweep builds group prefixes at positions 2**k*j - 1
		for (genvar l = 1; l <= m; l++) begin : g_up
			localparam int half = 2**(l-1);
			for (genvar i = 0; i < width; i++) begin : g_bit
				if ((i + 1) % (2*half) == 0) begin : g_black
					assign t[l][i] = t[l-1][i] & t[l-1][i-half];
				end else begin : g_white
					assign t[l][i] = t[l-1][i];
				end
			end
		end

		// Down-sweep fills in the positions the up-sweep skipped
		for (genvar d = m + 1; d <= last; d++) begin : g_down
			localparam int half = 2**(2*m - d - 1);  // Shrinks to 1
			for (genvar i = 0; i < width; i++) begin : g_bit
				if (((i + 1) % (2*half) == half) && (i >= 2*half)) begin : g_black
					assign t[d][i] = t[d-1][i] & t[d-1][i-half];  // Left neighbour done
				end else begin : g_white
					assign t[d][i] = t[d-1][i];
				end
			end
		end
		assign po = t[last];
	end else begin : g_serial
		wire [width-1:0] t;  // Ripple chain

		assign t[0] = pi[0];
		for (genvar i = 1; i < width; i++) begin : g_bit
			assign t[i] = t[i-1] & pi[i];
		end
		assign po = t;
	end

endmodule

`default_nettype wire

// ==== hdl/sad_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and payload types of the SAD datapath.
// Pixels are unsigned PIX_W bits. Lane 0 sits in the low bits of an item.
// SUM_W covers LANES * 255 * MAX_BLOCK. Longer blocks wrap modulo 2**SUM_W.
// The accumulator adder tree is written for LANES = 4.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sad_pkg;

	localparam int PIX_W     = 8;          // Unsigned pixel
	localparam int DIFF_W    = PIX_W + 1;  // Signed cur minus ref
	localparam int LANES     = 4;          // Pixel pairs per item
	localparam int MAX_BLOCK = 16;         // Longest block free of wrap

	// Enough bits for a full block of worst-case lanes
	localparam int SUM_W = $clog2(LANES * (2**PIX_W - 1) * MAX_BLOCK + 1);

	// One pixel pair, current block against candidate
	typedef struct packed {
		logic [PIX_W-1:0] cur;      // Current frame
		logic [PIX_W-1:0] ref_pix;  // Reference frame
	} pix_pair_t;

	// One input item, all lanes side by side
	typedef struct packed {
		pix_pair_t [LANES-1:0] pair;
	} sad_item_t;

	// Registered lane magnitudes, one per lane
	typedef logic [LANES-1:0][PIX_W-1:0] mag_vec_t;

endpackage

`default_nettype wire

// ==== hdl/lau_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic library helpers shared by the prefix-based blocks.
// speed_e picks the prefix structure. Encoding 2'b11 is not defined.
// log2floor is for elaboration and testbench sizing and expects n >= 1.
// It returns -1 for n <= 0, and p overflows for n near 2**31.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lau_pkg;

	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // Serial chain
		MEDIUM = 2'b01,  // Brent-Kung
		FAST   = 2'b10   // Sklansky
	} speed_e;

	// Floor of log2 of a positive n
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m++;
			p = p * 2;  // Next power of two
		end
		return m;
	endfunction

endpackage

`default_nettype wire
